//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := tb_gb_cart
FILELIST  := gb_cart.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "sim passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- gb_cart.f
src/gb_cart_pkg.sv
src/cart_header.sv
src/mbc_regs.sv
src/bank_mapper.sv
src/cart_ram.sv
src/gb_cart.sv
test/gb_cart_assert.sv
test/tb_gb_cart.sv

//--- src/bank_mapper.sv
/*
 * address translation
 *  - cpu rom reads to a 23 bit rom byte address
 *  - cpu cart ram accesses to a 17 bit ram byte address
 */

`timescale 1ns/1ps

module bank_mapper (
	input  gb_cart_pkg::cart_addr_t  cart_addr,
	input  gb_cart_pkg::mbc_kind_t   mbc_kind,
	input  gb_cart_pkg::rom_bank_t   rom_mask,
	input  gb_cart_pkg::ram_bank_t   ram_mask,
	input  gb_cart_pkg::rom_bank_t   rom_bank_reg,
	input  gb_cart_pkg::ram_bank_t   ram_bank_reg,
	input  logic                     mbc1_mode,
	output gb_cart_pkg::rom_addr_t   rom_addr_next,
	output gb_cart_pkg::cram_addr_t  cram_addr
);

	gb_cart_pkg::rom_bank_t rom_bank;  // masked bank for 4000-7FFF
	gb_cart_pkg::ram_bank_t ram_bank;  // masked bank for A000-BFFF

	// ------------------------------------------------
	// rom bank select
	// ------------------------------------------------
	always_comb begin
		case (mbc_kind)
			// ram bank bits act as rom bits 6:5 in mode 0
			gb_cart_pkg::mbc_1: rom_bank = {2'b00, (mbc1_mode ? 2'b00 : ram_bank_reg[1:0]),
				rom_bank_reg[4:0]} & rom_mask;
			gb_cart_pkg::mbc_5: rom_bank = rom_bank_reg & rom_mask;  // full 9 bits
			default:            rom_bank = {2'b00, rom_bank_reg[6:0]} & rom_mask;
		endcase
	end

	always_comb begin
		if (mbc_kind == gb_cart_pkg::mbc_none)
			rom_addr_next = {8'd0, cart_addr[14:0]};          // flat 32 KB
		else if (!cart_addr[14])
			rom_addr_next = {9'd0, cart_addr[13:0]};          // fixed bank 0
		else
			rom_addr_next = {rom_bank, cart_addr[13:0]};      // switchable bank
	end

	// ------------------------------------------------
	// ram bank select
	// ------------------------------------------------
	always_comb begin
		case (mbc_kind)
			gb_cart_pkg::mbc_1: ram_bank = (mbc1_mode ? ram_bank_reg : 4'd0) & ram_mask;
			gb_cart_pkg::mbc_3,
			gb_cart_pkg::mbc_5: ram_bank = ram_bank_reg & ram_mask;
			default:            ram_bank = 4'd0;  // mbc2 and plain carts unbanked
		endcase
	end

	assign cram_addr = {ram_bank, cart_addr[12:0]};  // 8 KB window per bank

endmodule

//--- src/cart_header.sv
/*
 * cartridge header capture
 *  - latches type, rom size and ram size bytes during download
 *  - decodes mbc kind, rom bank mask and ram bank mask
 */

`timescale 1ns/1ps

module cart_header (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_active,  // image download in progress
	input  logic                   dl_wr,      // one byte strobe
	input  gb_cart_pkg::rom_addr_t dl_addr,
	input  gb_cart_pkg::cart_data_t dl_data,
	output gb_cart_pkg::mbc_kind_t mbc_kind,
	output gb_cart_pkg::rom_bank_t rom_mask,
	output gb_cart_pkg::ram_bank_t ram_mask
);

	gb_cart_pkg::cart_data_t cart_mbc_type;  // raw header bytes
	gb_cart_pkg::cart_data_t cart_rom_size;
	gb_cart_pkg::cart_data_t cart_ram_size;

	// ------------------------------------------------
	// header byte capture
	// ------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_mbc_type <= 8'h00;  // no mbc
			cart_rom_size <= 8'h00;  // 32 KB
			cart_ram_size <= 8'h00;  // no ram
		end else if (dl_active && dl_wr) begin
			case (dl_addr)
				gb_cart_pkg::hdr_mbc_type: cart_mbc_type <= dl_data;
				gb_cart_pkg::hdr_rom_size: cart_rom_size <= dl_data;
				gb_cart_pkg::hdr_ram_size: cart_ram_size <= dl_data;
				default: ;  // rest of the image is not ours
			endcase
		end
	end

	// ------------------------------------------------
	// decode
	// ------------------------------------------------
	always_comb begin
		case (cart_mbc_type) inside
			[8'h01:8'h03]: mbc_kind = gb_cart_pkg::mbc_1;  // rom, +ram, +battery
			[8'h05:8'h06]: mbc_kind = gb_cart_pkg::mbc_2;
			[8'h0F:8'h13]: mbc_kind = gb_cart_pkg::mbc_3;  // with and without timer
			[8'h19:8'h1E]: mbc_kind = gb_cart_pkg::mbc_5;  // incl. rumble variants
			default:       mbc_kind = gb_cart_pkg::mbc_none;
		endcase
	end

	// code n means 2^(n+1) banks of 16 KB
	always_comb begin
		if (cart_rom_size <= 8'd8)
			rom_mask = gb_cart_pkg::rom_bank_t'((10'd2 << cart_rom_size[3:0]) - 10'd1);
		else
			rom_mask = 9'h07F;  // odd sizes 0x52-0x54 mirror as 128 banks
	end

	always_comb begin
		case (cart_ram_size)
			8'h00, 8'h01, 8'h02: ram_mask = 4'h0;  // none, 2 KB or 8 KB, one bank
			8'h03:               ram_mask = 4'h3;  // 32 KB, 4 banks
			default:             ram_mask = 4'hF;  // 128 KB, 16 banks
		endcase
	end

endmodule

//--- src/cart_ram.sv
/*
 * banked cartridge ram
 *  - one byte per address, synchronous read
 *  - read-back rules for disabled ram, mbc2 nibbles and mbc3 rtc mode
 */

`timescale 1ns/1ps

module cart_ram #(
	parameter int ADDR_W = 17  // 128 KB
) (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic [ADDR_W-1:0]       cram_addr,
	input  gb_cart_pkg::cart_data_t cart_di,
	input  logic                    wr,          // store to A000-BFFF
	input  logic                    rd,          // load from A000-BFFF
	input  logic                    ram_enable,
	input  logic                    rtc_mode,
	input  gb_cart_pkg::mbc_kind_t  mbc_kind,
	output logic                    cram_valid,  // cart_do holds read data
	output gb_cart_pkg::cart_data_t cart_do
);

	gb_cart_pkg::cart_data_t mem [0:(1 << ADDR_W) - 1];

	gb_cart_pkg::cart_data_t ram_q;  // raw byte read
	logic q_enable;                   // flags captured with the read
	logic q_nibble;
	logic q_rtc;

	always_ff @(posedge clk_sys) begin
		if (wr) mem[cram_addr] <= cart_di;  // enable not checked on stores
		if (rd) begin
			ram_q    <= mem[cram_addr];
			q_enable <= ram_enable;
			q_nibble <= (mbc_kind == gb_cart_pkg::mbc_2);
			q_rtc    <= rtc_mode;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) cram_valid <= 1'b0;
		else       cram_valid <= rd;  // one cycle read latency
	end

	// disabled wins, then mbc2 nibble, then rtc
	always_comb begin
		if (!q_enable)     cart_do = 8'hFF;
		else if (q_nibble) cart_do = {4'hF, ram_q[3:0]};  // 4 bit ram, top half open
		else if (q_rtc)    cart_do = 8'h00;               // no rtc behind it
		else               cart_do = ram_q;
	end

endmodule

//--- src/gb_cart.sv
/*
 * cartridge mapper top level
 *  - region decode of the cpu bus
 *  - header, mbc registers, bank mapper and cart ram
 *  - registered rom read strobe and address
 */

`timescale 1ns/1ps

module gb_cart #(
	parameter int CRAM_ADDR_W = $bits(gb_cart_pkg::cram_addr_t)
) (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    dl_active,
	input  logic                    dl_wr,
	input  gb_cart_pkg::rom_addr_t  dl_addr,
	input  gb_cart_pkg::cart_data_t dl_data,
	input  gb_cart_pkg::cart_addr_t cart_addr,
	input  logic                    cart_rd,
	input  logic                    cart_wr,
	input  gb_cart_pkg::cart_data_t cart_di,
	output logic                    rom_rd,      // one cycle after a rom region cart_rd
	output gb_cart_pkg::rom_addr_t  rom_addr,
	output logic                    cram_valid,
	output gb_cart_pkg::cart_data_t cart_do
);

	gb_cart_pkg::mbc_kind_t  mbc_kind;
	gb_cart_pkg::rom_bank_t  rom_mask, rom_bank_reg;
	gb_cart_pkg::ram_bank_t  ram_mask, ram_bank_reg;
	logic                    mbc1_mode, rtc_mode, ram_enable;
	gb_cart_pkg::rom_addr_t  rom_addr_next;
	gb_cart_pkg::cram_addr_t cram_addr;
	logic                    is_rom, is_cram;  // region decode on bits 15:13

	assign is_rom  = !cart_addr[15];                 // 0000-7FFF
	assign is_cram = (cart_addr[15:13] == 3'b101);   // A000-BFFF

	// ------------------------------------------------
	// rom read pipeline, cpu is idle while downloading
	// ------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) rom_rd <= 1'b0;
		else       rom_rd <= cart_rd && is_rom && !dl_active;
		if (cart_rd && is_rom) rom_addr <= rom_addr_next;  // held between reads
	end

	cart_header u_header (.clk_sys, .reset, .dl_active, .dl_wr, .dl_addr, .dl_data,
		.mbc_kind, .rom_mask, .ram_mask);

	mbc_regs u_regs (.clk_sys, .reset, .dl_active, .reg_wr(cart_wr && is_rom),
		.cart_addr, .cart_di, .mbc_kind, .rom_bank_reg, .ram_bank_reg, .mbc1_mode,
		.rtc_mode, .ram_enable);

	bank_mapper u_mapper (.cart_addr, .mbc_kind, .rom_mask, .ram_mask, .rom_bank_reg,
		.ram_bank_reg, .mbc1_mode, .rom_addr_next, .cram_addr);

	cart_ram #(.ADDR_W(CRAM_ADDR_W)) u_cram (
		.clk_sys,
		.reset,
		.cram_addr  (cram_addr[CRAM_ADDR_W-1:0]),
		.cart_di,
		.wr         (cart_wr && is_cram && !dl_active),
		.rd         (cart_rd && is_cram && !dl_active),
		.ram_enable,
		.rtc_mode,
		.mbc_kind,
		.cram_valid,
		.cart_do
	);

endmodule

//--- src/gb_cart_pkg.sv
/*
 * shared cartridge definitions
 *  - bus, bank and address vector types
 *  - mbc kind enum
 *  - header field byte offsets within the rom image
 */

package gb_cart_pkg;

	// ------------------------------------------------
	// vector types
	// ------------------------------------------------
	typedef logic [15:0] cart_addr_t;  // cpu address on the cart bus
	typedef logic [7:0]  cart_data_t;  // cpu / download / header byte
	typedef logic [8:0]  rom_bank_t;   // rom bank number or mask, 512 banks
	typedef logic [3:0]  ram_bank_t;   // ram bank number or mask, 16 banks
	typedef logic [22:0] rom_addr_t;   // byte address, up to 8 MB of rom
	typedef logic [16:0] cram_addr_t;  // byte address, 128 KB of cart ram

	// mapper family decoded from the header type byte
	typedef enum logic [2:0] {
		mbc_none,  // plain 32 KB rom
		mbc_1,
		mbc_2,     // 512 x 4 bit internal ram
		mbc_3,     // rtc mode reads back as 00
		mbc_5
	} mbc_kind_t;

	// ------------------------------------------------
	// header offsets
	// ------------------------------------------------
	localparam rom_addr_t hdr_mbc_type = 23'h000147;  // cartridge type
	localparam rom_addr_t hdr_rom_size = 23'h000148;  // rom size code
	localparam rom_addr_t hdr_ram_size = 23'h000149;  // ram size code

endpackage

//--- src/mbc_regs.sv
/*
 * mbc control registers
 *  - ram enable, rom bank, ram bank / rtc select, mbc1 mode
 *  - written by cpu stores to 0000-7FFF
 */

`timescale 1ns/1ps

module mbc_regs (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    dl_active,     // holds registers at reset values
	input  logic                    reg_wr,        // store into 0000-7FFF
	input  gb_cart_pkg::cart_addr_t cart_addr,
	input  gb_cart_pkg::cart_data_t cart_di,
	input  gb_cart_pkg::mbc_kind_t  mbc_kind,
	output gb_cart_pkg::rom_bank_t  rom_bank_reg,
	output gb_cart_pkg::ram_bank_t  ram_bank_reg,
	output logic                    mbc1_mode,     // 1 = 4/32 mode
	output logic                    rtc_mode,      // mbc3 rtc register mapped
	output logic                    ram_enable
);

	logic is_mbc1;
	logic is_mbc3;
	logic is_mbc5;

	assign is_mbc1 = (mbc_kind == gb_cart_pkg::mbc_1);
	assign is_mbc3 = (mbc_kind == gb_cart_pkg::mbc_3);
	assign is_mbc5 = (mbc_kind == gb_cart_pkg::mbc_5);

	// ------------------------------------------------
	// register writes, region from address bits 14:13
	// ------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset || dl_active) begin
			rom_bank_reg <= 9'd1;  // bank 1 visible at 4000
			ram_bank_reg <= 4'd0;
			mbc1_mode    <= 1'b0;
			rtc_mode     <= 1'b0;
			ram_enable   <= 1'b0;
		end else if (reg_wr) begin
			case (cart_addr[14:13])
				// 0000-1FFF ram enable, magic value A in low nibble
				2'b00: ram_enable <= (cart_di[3:0] == 4'hA);
				// 2000-3FFF rom bank
				2'b01: begin
					if (is_mbc5) begin
						if (cart_addr[12])
							rom_bank_reg[8] <= cart_di[0];    // 3xxx high bit
						else
							rom_bank_reg[7:0] <= cart_di;     // 2xxx low byte
					end else if (cart_di[6:0] == 7'd0) begin
						rom_bank_reg <= 9'd1;                 // bank 0 maps to 1
					end else begin
						rom_bank_reg <= {2'b00, cart_di[6:0]};
					end
				end
				// 4000-5FFF ram bank, or rtc select on mbc3
				2'b10: begin
					if (is_mbc3) begin
						if (cart_di[3]) begin
							rtc_mode <= 1'b1;
						end else begin
							rtc_mode     <= 1'b0;
							ram_bank_reg <= {2'b00, cart_di[1:0]};
						end
					end else if (is_mbc5) begin
						ram_bank_reg <= cart_di[3:0];         // 16 banks
					end else begin
						ram_bank_reg <= {2'b00, cart_di[1:0]};
					end
				end
				// 6000-7FFF banking mode, mbc1 only
				default: if (is_mbc1) mbc1_mode <= cart_di[0];
			endcase
		end
	end

endmodule

//--- test/gb_cart_assert.sv
/*
 * concurrent checks on the cartridge strobes
 *  - rom and ram read strobes exclusive, quiet in reset and download
 */

`timescale 1ns/1ps

module gb_cart_assert (
	input logic clk_sys,
	input logic reset,
	input logic dl_active,
	input logic cart_rd,
	input logic rom_rd,
	input logic cram_valid
);

	a_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(rom_rd && cram_valid)) else $error("rom_rd and cram_valid high together");

	a_quiet: assert property (@(posedge clk_sys) (reset || dl_active) |=>
		!(rom_rd || cram_valid)) else $error("read strobe during reset or download");

	a_rom_cause: assert property (@(posedge clk_sys) disable iff (reset)
		rom_rd |-> $past(cart_rd)) else $error("rom_rd without a cart_rd before it");

	a_ram_cause: assert property (@(posedge clk_sys) disable iff (reset)
		cram_valid |-> $past(cart_rd)) else $error("cram_valid without a cart_rd before it");

endmodule

bind gb_cart gb_cart_assert u_assert (.clk_sys, .reset, .dl_active, .cart_rd, .rom_rd,
	.cram_valid);

//--- test/tb_gb_cart.sv
/*
 * testbench for the cartridge mapper
 *  - header download, cpu register stores, rom and cart ram loads
 *  - reference model of banking and ram, queued compare, watchdog
 */

`timescale 1ns/1ps

module tb_gb_cart;

	localparam int n_reads     = 24;                      // loop length per test
	localparam int n_accesses  = 18 * n_reads + 32;       // bus cycles over all five tests
	localparam int watchdog_ns = 2 * 8 * (10 + 5 * 20 + n_accesses);  // 2x margin

	logic clk_sys = 1'b0;
	logic reset, dl_active, dl_wr, cart_rd, cart_wr, rom_rd, cram_valid;
	gb_cart_pkg::rom_addr_t  dl_addr, rom_addr;
	gb_cart_pkg::cart_data_t dl_data, cart_di, cart_do;
	gb_cart_pkg::cart_addr_t cart_addr;

	logic [15:0] lfsr = 16'd16;
	// reference model state
	gb_cart_pkg::mbc_kind_t  m_kind;
	gb_cart_pkg::rom_bank_t  m_rom_mask, m_rom_bank;
	gb_cart_pkg::ram_bank_t  m_ram_mask, m_ram_bank;
	logic                    m_mode, m_rtc, m_ram_en;
	gb_cart_pkg::cart_data_t m_mem [0:(1 << 17) - 1];
	gb_cart_pkg::rom_addr_t  exp_rom [$];  // outstanding reads
	gb_cart_pkg::cart_data_t exp_ram [$];
	logic [19:0]             saved [$];    // {bank, cpu address} of ram stores

	always #4 clk_sys = ~clk_sys;

	gb_cart dut_i (.*);

	// galois lfsr with taps 16 14 13 11
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 16'hB400 : 16'h0000);
		end
		return v;
	endfunction

	// ------------------------------------------------
	// reference model
	// ------------------------------------------------
	function automatic gb_cart_pkg::cram_addr_t ram_index(input gb_cart_pkg::cart_addr_t a);
		gb_cart_pkg::ram_bank_t b;
		case (m_kind)
			gb_cart_pkg::mbc_1: b = m_mode ? (m_ram_bank & m_ram_mask) : 4'd0;
			gb_cart_pkg::mbc_3, gb_cart_pkg::mbc_5: b = m_ram_bank & m_ram_mask;
			default: b = 4'd0;
		endcase
		return {b, a[12:0]};
	endfunction

	function automatic gb_cart_pkg::rom_addr_t ref_rom_addr(input gb_cart_pkg::cart_addr_t a);
		gb_cart_pkg::rom_bank_t b;
		case (m_kind)
			gb_cart_pkg::mbc_1: b = {2'b00, (m_mode ? 2'b00 : m_ram_bank[1:0]), m_rom_bank[4:0]};
			gb_cart_pkg::mbc_5: b = m_rom_bank;
			default:            b = {2'b00, m_rom_bank[6:0]};
		endcase
		if (m_kind == gb_cart_pkg::mbc_none) return {8'd0, a[14:0]};
		if (!a[14]) return {9'd0, a[13:0]};  // fixed bank 0
		return {b & m_rom_mask, a[13:0]};
	endfunction

	function automatic gb_cart_pkg::cart_data_t ref_ram_read(input gb_cart_pkg::cart_addr_t a);
		gb_cart_pkg::cart_data_t q;
		q = m_mem[ram_index(a)];
		if (!m_ram_en) return 8'hFF;
		if (m_kind == gb_cart_pkg::mbc_2) return {4'hF, q[3:0]};
		if (m_rtc) return 8'h00;
		return q;
	endfunction

	task automatic model_store(input gb_cart_pkg::cart_addr_t a, input gb_cart_pkg::cart_data_t d);
		if (a[15:13] == 3'b101) begin
			m_mem[ram_index(a)] = d;  // stored even when disabled
		end else if (!a[15]) begin
			case (a[14:13])
				2'd0: m_ram_en = (d[3:0] == 4'hA);
				2'd1: begin
					if (m_kind == gb_cart_pkg::mbc_5 && a[12]) m_rom_bank[8] = d[0];
					else if (m_kind == gb_cart_pkg::mbc_5) m_rom_bank[7:0] = d;
					else m_rom_bank = (d[6:0] == 7'd0) ? 9'd1 : {2'b00, d[6:0]};
				end
				2'd2: begin
					if (m_kind == gb_cart_pkg::mbc_3) m_rtc = d[3];
					if (m_kind == gb_cart_pkg::mbc_5) m_ram_bank = d[3:0];
					else if (!(m_kind == gb_cart_pkg::mbc_3 && d[3])) m_ram_bank = {2'b00, d[1:0]};
				end
				default: if (m_kind == gb_cart_pkg::mbc_1) m_mode = d[0];
			endcase
		end
	endtask

	// ------------------------------------------------
	// bus tasks
	// ------------------------------------------------
	task automatic download(input gb_cart_pkg::cart_data_t kind, rom_code, ram_code);
		@(posedge clk_sys);
		cart_rd   <= 1'b0;
		cart_wr   <= 1'b0;
		dl_active <= 1'b1;
		for (gb_cart_pkg::rom_addr_t i = 23'h140; i < 23'h150; i++) begin
			@(posedge clk_sys);
			dl_wr     <= 1'b1;
			dl_addr   <= i;
			cart_rd   <= 1'b1;                          // cpu loads dropped while downloading
			cart_addr <= i[0] ? 16'hA000 : 16'h4000;    // ram and rom region in turn
			if (i == gb_cart_pkg::hdr_mbc_type) dl_data <= kind;
			else if (i == gb_cart_pkg::hdr_rom_size) dl_data <= rom_code;
			else if (i == gb_cart_pkg::hdr_ram_size) dl_data <= ram_code;
			else dl_data <= 8'(rand_bits(8));  // title and checksum filler
		end
		@(posedge clk_sys);
		dl_wr     <= 1'b0;
		dl_active <= 1'b0;
		cart_rd   <= 1'b0;
		if (kind >= 8'h01 && kind <= 8'h03) m_kind = gb_cart_pkg::mbc_1;
		else if (kind >= 8'h05 && kind <= 8'h06) m_kind = gb_cart_pkg::mbc_2;
		else if (kind >= 8'h0F && kind <= 8'h13) m_kind = gb_cart_pkg::mbc_3;
		else if (kind >= 8'h19 && kind <= 8'h1E) m_kind = gb_cart_pkg::mbc_5;
		else m_kind = gb_cart_pkg::mbc_none;
		m_rom_mask = (rom_code <= 8'd8) ? 9'((1 << (rom_code + 8'd1)) - 1) : 9'h07F;
		m_ram_mask = (ram_code <= 8'd2) ? 4'h0 : ((ram_code == 8'd3) ? 4'h3 : 4'hF);
		m_rom_bank = 9'd1;  // registers held at reset during download
		m_ram_bank = 4'd0;
		m_mode     = 1'b0;
		m_rtc      = 1'b0;
		m_ram_en   = 1'b0;
	endtask

	task automatic cpu_write(input gb_cart_pkg::cart_addr_t a, input gb_cart_pkg::cart_data_t d);
		@(posedge clk_sys);
		cart_addr <= a;
		cart_di   <= d;
		cart_rd   <= 1'b0;
		cart_wr   <= 1'b1;
		model_store(a, d);
	endtask

	task automatic cpu_read(input gb_cart_pkg::cart_addr_t a);
		@(posedge clk_sys);
		cart_addr <= a;
		cart_wr   <= 1'b0;
		cart_rd   <= 1'b1;
		if (a[15]) exp_ram.push_back(ref_ram_read(a));
		else exp_rom.push_back(ref_rom_addr(a));
	endtask

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want)
			stop_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, want));
	endtask

	// outputs sampled mid cycle
	initial begin
		forever begin
			@(negedge clk_sys);
			if (rom_rd) begin
				if (exp_rom.size() == 0) stop_run("rom_rd came with no rom read outstanding");
				check("rom_addr", 32'(rom_addr), 32'(exp_rom.pop_front()));
			end
			if (cram_valid) begin
				if (exp_ram.size() == 0) stop_run("cram_valid came with no ram read outstanding");
				check("cart_do", 32'(cart_do), 32'(exp_ram.pop_front()));
			end
		end
	end

	initial begin
		#(watchdog_ns);
		stop_run("watchdog expired before the tests finished");
	end

	// ------------------------------------------------
	// stimulus
	// ------------------------------------------------
	initial begin
		gb_cart_pkg::cart_addr_t a;
		gb_cart_pkg::cart_data_t d;
		reset     <= 1'b1;
		dl_active <= 1'b0;
		dl_wr     <= 1'b0;
		dl_addr   <= '0;
		dl_data   <= '0;
		cart_addr <= '0;
		cart_rd   <= 1'b0;
		cart_wr   <= 1'b0;
		cart_di   <= '0;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;

		download(8'h00, 8'h00, 8'h00);  // plain rom with flat 32 KB
		repeat (n_reads) cpu_read(gb_cart_pkg::cart_addr_t'(rand_bits(15)));

		download(8'h01, 8'h05, 8'h03);  // mbc1 with 64 banks
		for (int m = 0; m < 2; m++) begin
			cpu_write(16'h6000, 8'(m));
			for (int i = 0; i < n_reads; i++) begin
				d = (i % 4 == 0) ? 8'h00 : 8'(rand_bits(8));  // bank 0 now and then
				cpu_write(16'h2000 | 16'(rand_bits(13)), d);
				cpu_write(16'h4000 | 16'(rand_bits(13)), 8'(rand_bits(2)));
				cpu_read(16'h4000 | 16'(rand_bits(14)));
				cpu_read(16'(rand_bits(14)));
			end
		end

		download(8'h19, 8'h08, 8'h00);  // mbc5 with 512 banks
		for (int i = 0; i < n_reads; i++) begin
			cpu_write(16'h2000 | 16'(rand_bits(12)), 8'(rand_bits(8)));
			cpu_write(16'h3000 | 16'(rand_bits(12)), 8'(rand_bits(1)));
			cpu_read(16'h4000 | 16'(rand_bits(14)));
		end

		download(8'h13, 8'h00, 8'h03);  // mbc3 with 4 ram banks
		cpu_write(16'h0000, 8'h0A);
		for (int i = 0; i < n_reads; i++) begin
			d = 8'(rand_bits(2));
			a = 16'hA000 | 16'(rand_bits(13));
			cpu_write(16'h4000, d);
			cpu_write(a, 8'(rand_bits(8)));
			saved.push_back({d[3:0], a});
		end
		foreach (saved[i]) begin
			cpu_write(16'h4000, {4'h0, saved[i][19:16]});
			cpu_read(saved[i][15:0]);
		end
		cpu_write(16'h0000, 8'h00);  // disabled ram reads give FF
		for (int i = 0; i < 4; i++) cpu_read(saved[i][15:0]);
		cpu_write(16'h0000, 8'h0A);
		cpu_write(16'h4000, 8'h08);  // rtc register selected
		cpu_read(saved[0][15:0]);
		cpu_write(16'h4000, 8'h01);
		cpu_read(saved[1][15:0]);

		download(8'h05, 8'h02, 8'h00);  // mbc2 nibble ram
		cpu_write(16'h0000, 8'h0A);
		for (int i = 0; i < n_reads; i++) begin
			a = 16'hA000 | 16'(rand_bits(13));
			cpu_write(a, 8'(rand_bits(8)));
			cpu_read(a);
		end

		@(posedge clk_sys);
		cart_rd <= 1'b0;
		cart_wr <= 1'b0;
		for (int t = 0; t < 8 && (exp_rom.size() + exp_ram.size()) != 0; t++)
			@(posedge clk_sys);
		if (exp_rom.size() == 0 && exp_ram.size() == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			stop_run("a read strobe never came for an outstanding read");
		end
	end

endmodule
